//--- src/acc_geom_pkg.sv
// ========================================
// Array fixed at 4x6, 24 accumulators per bank
// DMA words hold 8 accumulators, word index 0 to 2
// ========================================
`default_nettype none

package acc_geom_pkg;

    // ========================================
    // Array and bank geometry
    // ========================================
    localparam int N_ROWS    = 4;
    localparam int N_COLS    = 6;
    localparam int NUM_ACCS  = N_ROWS * N_COLS;
    localparam int ACC_W     = 32;
    // Accumulators packed into one DMA word
    localparam int LANES     = 8;
    localparam int NUM_WORDS = NUM_ACCS / LANES;
    localparam int ADDR_W    = 2;

    // One signed accumulator
    typedef logic signed [ACC_W-1:0] acc_t;

    // Array output, element 0 is row 0 col 0, row-major
    typedef acc_t [NUM_ACCS-1:0] psum_vec_t;

    // Eight accumulators headed for one DMA word
    typedef acc_t [LANES-1:0] lane_vec_t;

    // Scheduler strobes, each a single-cycle pulse
    typedef struct packed {
        logic acc_valid;
        logic acc_clear;
        logic tile_done;
    } acc_ctrl_t;

    // DMA read request, address is a word index
    typedef struct packed {
        logic              rd_en;
        logic [ADDR_W-1:0] rd_addr;
    } dma_req_t;

endpackage

`default_nettype wire

//--- src/requant_pkg.sv
// ========================================
// Scale is unsigned Q0.16, so gain stays below 1.0
// Output saturates to signed INT8
// ========================================
`default_nettype none

package requant_pkg;

    // ========================================
    // Output format
    // ========================================
    localparam int OUT_W       = 8;
    localparam int SCALE_W     = 16;
    localparam int SCALE_SHIFT = 16;
    localparam int Q_MAX       = 127;
    localparam int Q_MIN       = -128;
    localparam int DMA_W       = 64;

    // Requantization setup, held as a level by software
    typedef struct packed {
        logic               relu_en;
        logic [SCALE_W-1:0] scale;
    } quant_cfg_t;

    typedef logic signed [OUT_W-1:0] qbyte_t;

    // Lane 0 sits in the low byte
    typedef qbyte_t [acc_geom_pkg::LANES-1:0] dma_word_t;

    // One lane: ReLU, scale, arithmetic shift, clamp
    function automatic qbyte_t requantize(input acc_geom_pkg::acc_t acc,
                                          input quant_cfg_t cfg);
        acc_geom_pkg::acc_t                          relu_val;
        logic signed [acc_geom_pkg::ACC_W+SCALE_W:0] prod;
        logic signed [acc_geom_pkg::ACC_W+SCALE_W:0] shifted;
        // Negative input dropped to zero only when ReLU is on
        relu_val = (cfg.relu_en && acc < 0) ? '0 : acc;
        // Zero-extend scale so the multiply stays signed
        prod = relu_val * $signed({1'b0, cfg.scale});
        shifted = prod >>> SCALE_SHIFT;
        if (shifted > Q_MAX) begin
            return qbyte_t'(Q_MAX);
        end else if (shifted < Q_MIN) begin
            return qbyte_t'(Q_MIN);
        end
        return shifted[OUT_W-1:0];
    endfunction

endpackage

`default_nettype wire

//--- src/bank_ctrl.sv
// ========================================
// tile_done must not fall inside a read in flight
// ========================================
`default_nettype none

module bank_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  acc_geom_pkg::acc_ctrl_t ctrl,
    input  logic                    rd_en,
    output logic                    bank_sel,
    output logic                    dma_ready
);

    // One ready flag per bank, index is the bank number
    logic [1:0] ready;

    // ========================================
    // Bank selection and ready flags
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank_sel <= 1'b0;
            ready    <= 2'b00;
        end else begin
            // Finished bank becomes the DMA side
            if (ctrl.tile_done) begin
                bank_sel        <= ~bank_sel;
                ready[bank_sel] <= 1'b1;
            end
            // First read of the drained bank drops its flag
            // Never the same bank as the one tile_done marks
            if (rd_en) begin
                ready[~bank_sel] <= 1'b0;
            end
        end
    end

    // DMA always looks at the bank not being accumulated
    assign dma_ready = ready[~bank_sel];

    // ========================================
    // Checks
    // ========================================
    // Every tile_done must produce a swap on the next cycle
    a_swap_on_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        ctrl.tile_done |=> (bank_sel != $past(bank_sel))
    );

endmodule

`default_nettype wire

//--- src/accum_banks.sv
// ========================================
// Add wraps at 32 bits with no overflow flag
// bank_sel must hold steady across a read
// ========================================
`default_nettype none

module accum_banks (
    input  logic                    clk,
    input  logic                    rst_n,
    input  acc_geom_pkg::acc_ctrl_t ctrl,
    input  acc_geom_pkg::psum_vec_t psum,
    input  logic                    bank_sel,
    input  acc_geom_pkg::dma_req_t  dma,
    output acc_geom_pkg::lane_vec_t rd_lanes,
    output logic                    rd_valid
);

    // Two full banks, indexed by bank number
    acc_geom_pkg::psum_vec_t banks [0:1];

    // First accumulator index of the requested word
    logic [acc_geom_pkg::ADDR_W+$clog2(acc_geom_pkg::LANES)-1:0] rd_base;

    // DMA side is always the other bank
    logic rd_bank;

    // ========================================
    // Accumulate into the active bank
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            banks <= '{default: '0};
        end else if (ctrl.acc_clear) begin
            // Start of a new output tile
            banks[bank_sel] <= '0;
        end else if (ctrl.acc_valid) begin
            // All 24 lanes add in parallel
            for (int i = 0; i < acc_geom_pkg::NUM_ACCS; i++) begin
                banks[bank_sel][i] <= banks[bank_sel][i] + psum[i];
            end
        end
    end

    // ========================================
    // Read stage 1
    // ========================================
    // Word index times eight, as a shift
    assign rd_base = {dma.rd_addr, {$clog2(acc_geom_pkg::LANES){1'b0}}};
    assign rd_bank = ~bank_sel;

    // Lane register loads only on a read request
    always_ff @(posedge clk) begin
        if (dma.rd_en) begin
            rd_lanes <= banks[rd_bank][rd_base +: acc_geom_pkg::LANES];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= dma.rd_en;
        end
    end

    // ========================================
    // Checks
    // ========================================
    // Scheduler contract
    a_no_clear_and_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(ctrl.acc_clear && ctrl.acc_valid)
    );

    // Word 3 would index past the bank
    a_rd_addr_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        dma.rd_en |-> (dma.rd_addr < acc_geom_pkg::NUM_WORDS)
    );

    // Bank under read must not swap before the lanes are used
    a_sel_stable_in_read: assert property (
        @(posedge clk) disable iff (!rst_n)
        dma.rd_en |=> $stable(bank_sel)
    );

endmodule

`default_nettype wire

//--- src/requant_stage.sv
// ========================================
// qcfg is sampled on the second read cycle
// Output word holds until the next read
// ========================================
`default_nettype none

module requant_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  acc_geom_pkg::lane_vec_t  rd_lanes,
    input  logic                     rd_valid,
    input  requant_pkg::quant_cfg_t  qcfg,
    output requant_pkg::dma_word_t   dma_rd_data
);

    // Packed result of all eight lanes
    logic [requant_pkg::DMA_W-1:0] word_nxt;

    // ========================================
    // Requantize eight lanes
    // ========================================
    always_comb begin
        word_nxt = '0;
        for (int i = 0; i < acc_geom_pkg::LANES; i++) begin
            // Lane i lands in byte i
            word_nxt[i*requant_pkg::OUT_W +: requant_pkg::OUT_W] =
                requant_pkg::requantize(rd_lanes[i], qcfg);
        end
    end

    // ========================================
    // Read stage 2 register
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dma_rd_data <= '0;
        end else if (rd_valid) begin
            dma_rd_data <= word_nxt;
        end
    end

endmodule

`default_nettype wire

//--- src/accum_top.sv
// ========================================
// Plain strobes, no back-pressure anywhere
// DMA read latency is fixed at two cycles
// ========================================
`default_nettype none

module accum_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  acc_geom_pkg::acc_ctrl_t ctrl,
    input  acc_geom_pkg::psum_vec_t psum,
    input  requant_pkg::quant_cfg_t qcfg,
    input  acc_geom_pkg::dma_req_t  dma,
    output requant_pkg::dma_word_t  dma_rd_data,
    output logic                    dma_ready,
    output logic                    bank_sel
);

    // Stage 1 to stage 2 of the read path
    acc_geom_pkg::lane_vec_t rd_lanes;
    logic                    rd_valid;

    // Ping-pong selection and ready flags
    bank_ctrl i_bank_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .rd_en     (dma.rd_en),
        .bank_sel  (bank_sel),
        .dma_ready (dma_ready)
    );

    // Storage, accumulate and lane fetch
    accum_banks i_accum_banks (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl     (ctrl),
        .psum     (psum),
        .bank_sel (bank_sel),
        .dma      (dma),
        .rd_lanes (rd_lanes),
        .rd_valid (rd_valid)
    );

    // ReLU, scale and INT8 packing
    requant_stage i_requant_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_lanes    (rd_lanes),
        .rd_valid    (rd_valid),
        .qcfg        (qcfg),
        .dma_rd_data (dma_rd_data)
    );

endmodule

`default_nettype wire

//--- test/tb_accum_tasks.svh
// ========================================
// Tasks see the signals and model of tb_accum_top
// ========================================

    // ========================================
    // Checks and stimulus helpers
    // ========================================
    task automatic compare_value(input string name, input logic [63:0] want,
                                 input logic [63:0] got);
        assert (got === want) else begin
            $display("ERR %s: expected %h, actual %h", name, want, got);
            err_count++;
        end
    endtask

    task automatic log_test_result(input string name, input int errs_before);
        if (err_count == errs_before) begin
            pass_count++;
            $display("Test %s passed", name);
        end else begin
            fail_count++;
            $display("Test %s failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    // Single-cycle strobe, model follows at the same edge
    task automatic pulse_ctrl(input bit valid, input bit clear, input bit done,
                              input acc_geom_pkg::psum_vec_t vec);
        @(posedge clk);
        ctrl <= '{acc_valid: valid, acc_clear: clear, tile_done: done};
        psum <= vec;
        for (int i = 0; i < acc_geom_pkg::NUM_ACCS; i++) begin
            if (clear) begin
                model_bank[model_sel][i] = 0;
            end else if (valid) begin
                model_bank[model_sel][i] = model_bank[model_sel][i] + vec[i];
            end
        end
        if (done) begin
            model_ready[model_sel] = 1'b1;
            model_sel = !model_sel;
        end
        @(posedge clk);
        ctrl <= '0;
    endtask

    // Lanes in lo..hi, odd lanes negated when alt is set
    task automatic add_random_vector(input int lo, input int hi, input bit alt);
        acc_geom_pkg::psum_vec_t vec;
        int v;
        for (int i = 0; i < acc_geom_pkg::NUM_ACCS; i++) begin
            v = lo + int'($urandom_range(hi - lo));
            vec[i] = (alt && i % 2 == 1) ? -v : v;
        end
        pulse_ctrl(1'b1, 1'b0, 1'b0, vec);
    endtask

    task automatic build_tile(input int lo, input int hi, input bit alt);
        pulse_ctrl(1'b0, 1'b1, 1'b0, '0);
        repeat (3) add_random_vector(lo, hi, alt);
        pulse_ctrl(1'b0, 1'b0, 1'b1, '0);
    endtask

    // Word lands two edges after the rd_en edge
    task automatic read_word(input string name, input int addr);
        logic [63:0] want;
        @(posedge clk);
        dma <= '{rd_en: 1'b1, rd_addr: addr[1:0]};
        want = predict_word(!model_sel, addr);
        model_ready[!model_sel] = 1'b0;
        @(posedge clk);
        dma <= '0;
        @(posedge clk);
        @(negedge clk);
        compare_value(name, want, dma_rd_data);
        compare_value({name, " ready"}, model_ready[!model_sel], dma_ready);
    endtask

    // ========================================
    // Directed tests
    // ========================================
    task automatic reset_and_swap();
        int e0;
        e0 = err_count;
        @(negedge clk);
        compare_value("reset_and_swap", 0, dma_ready);
        compare_value("reset_and_swap", 0, bank_sel);
        compare_value("reset_and_swap", 0, dma_rd_data);
        // Small mixed-sign tile, reused by the next two tests
        build_tile(-150, 150, 1'b0);
        @(negedge clk);
        compare_value("reset_and_swap", 1, bank_sel);
        compare_value("reset_and_swap", 1, dma_ready);
        log_test_result("reset_and_swap", e0);
    endtask

    task automatic scale_mixed_signs();
        int e0;
        e0 = err_count;
        @(posedge clk);
        qcfg <= '{relu_en: 1'b0, scale: 16'h4000};
        for (int w = 0; w < acc_geom_pkg::NUM_WORDS; w++) begin
            read_word("scale_mixed_signs", w);
        end
        log_test_result("scale_mixed_signs", e0);
    endtask

    task automatic relu_clamps_negatives();
        int e0;
        e0 = err_count;
        @(posedge clk);
        qcfg <= '{relu_en: 1'b1, scale: 16'h4000};
        for (int w = 0; w < acc_geom_pkg::NUM_WORDS; w++) begin
            read_word("relu_clamps_negatives", w);
            // No lane may come out negative
            for (int i = 0; i < acc_geom_pkg::LANES; i++) begin
                compare_value("relu_clamps_negatives sign", 0, dma_rd_data[i][7]);
            end
        end
        log_test_result("relu_clamps_negatives", e0);
    endtask

    task automatic saturate_to_int8();
        int e0;
        e0 = err_count;
        @(posedge clk);
        qcfg <= '{relu_en: 1'b0, scale: 16'hffff};
        // Even lanes large positive, odd lanes large negative
        build_tile(40000000, 60000000, 1'b1);
        for (int w = 0; w < acc_geom_pkg::NUM_WORDS; w++) begin
            read_word("saturate_to_int8", w);
            compare_value("saturate_to_int8 clamp", 64'h807f_807f_807f_807f, dma_rd_data);
        end
        log_test_result("saturate_to_int8", e0);
    endtask

    task automatic ping_pong_banks();
        int e0;
        e0 = err_count;
        @(posedge clk);
        qcfg <= '{relu_en: 1'b0, scale: 16'h4000};
        build_tile(-200, 200, 1'b0);
        @(negedge clk);
        compare_value("ping_pong_banks", 1, bank_sel);
        compare_value("ping_pong_banks", 1, dma_ready);
        // Next tile fills bank 1 between reads of bank 0
        pulse_ctrl(1'b0, 1'b1, 1'b0, '0);
        for (int w = 0; w < acc_geom_pkg::NUM_WORDS; w++) begin
            add_random_vector(-200, 200, 1'b0);
            read_word("ping_pong_banks bank 0", w);
            compare_value("ping_pong_banks ready drop", 0, dma_ready);
        end
        pulse_ctrl(1'b0, 1'b0, 1'b1, '0);
        @(negedge clk);
        compare_value("ping_pong_banks", 0, bank_sel);
        compare_value("ping_pong_banks", 1, dma_ready);
        for (int w = 0; w < acc_geom_pkg::NUM_WORDS; w++) begin
            read_word("ping_pong_banks bank 1", w);
        end
        log_test_result("ping_pong_banks", e0);
    endtask

    // One rd_en per cycle, one word per cycle two edges later
    task automatic back_to_back_reads();
        int e0;
        logic [63:0] want [3];
        e0 = err_count;
        for (int w = 0; w < acc_geom_pkg::NUM_WORDS; w++) begin
            want[w] = predict_word(!model_sel, w);
        end
        model_ready[!model_sel] = 1'b0;
        for (int c = 0; c < acc_geom_pkg::NUM_WORDS + 2; c++) begin
            @(posedge clk);
            if (c < acc_geom_pkg::NUM_WORDS) begin
                dma <= '{rd_en: 1'b1, rd_addr: c[1:0]};
            end else begin
                dma <= '0;
            end
            if (c >= 2) begin
                @(negedge clk);
                compare_value("back_to_back_reads", want[c-2], dma_rd_data);
            end
        end
        compare_value("back_to_back_reads ready", 0, dma_ready);
        log_test_result("back_to_back_reads", e0);
    endtask

//--- test/tb_accum_top.sv
// ========================================
// Directed tests checked against a behavioral model
// Tests share bank state and must run in order
// ========================================
`default_nettype none

module tb_accum_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 16;
    // Per-test cycle budgets, in test order, summed for the watchdog
    localparam int BUDGET_CYCLES = 20 + 20 + 20 + 40 + 70 + 15;

    logic                    clk;
    logic                    rst_n;
    acc_geom_pkg::acc_ctrl_t ctrl;
    acc_geom_pkg::psum_vec_t psum;
    requant_pkg::quant_cfg_t qcfg;
    acc_geom_pkg::dma_req_t  dma;
    requant_pkg::dma_word_t  dma_rd_data;
    logic                    dma_ready;
    logic                    bank_sel;

    // Model banks, selection and ready flags
    int model_bank [2][acc_geom_pkg::NUM_ACCS];
    bit model_ready [2];
    bit model_sel;

    int err_count  = 0;
    int pass_count = 0;
    int fail_count = 0;

    accum_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctrl        (ctrl),
        .psum        (psum),
        .qcfg        (qcfg),
        .dma         (dma),
        .dma_rd_data (dma_rd_data),
        .dma_ready   (dma_ready),
        .bank_sel    (bank_sel)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ========================================
    // Reference model
    // ========================================
    // One lane: ReLU, times Q0.16 scale, shift by 16, clamp to INT8
    function automatic logic [7:0] lane_model(input int acc, input bit relu,
                                              input logic [15:0] scale);
        longint v;
        longint p;
        v = (relu && acc < 0) ? 0 : acc;
        p = v * longint'(scale);
        p = p >>> 16;
        if (p > requant_pkg::Q_MAX) begin
            return 8'h7f;
        end
        if (p < requant_pkg::Q_MIN) begin
            return 8'h80;
        end
        return p[7:0];
    endfunction

    // Word addr of a model bank, lane 0 in the low byte
    function automatic logic [63:0] predict_word(input bit bank, input int addr);
        logic [63:0] w;
        w = '0;
        for (int i = 0; i < acc_geom_pkg::LANES; i++) begin
            w[i*8 +: 8] = lane_model(model_bank[bank][addr*acc_geom_pkg::LANES + i],
                                     qcfg.relu_en, qcfg.scale);
        end
        return w;
    endfunction

    `include "tb_accum_tasks.svh"

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        void'($urandom(92));
        rst_n <= 1'b0;
        ctrl  <= '0;
        psum  <= '0;
        qcfg  <= '0;
        dma   <= '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        reset_and_swap();
        scale_mixed_signs();
        relu_clamps_negatives();
        saturate_to_int8();
        ping_pong_banks();
        back_to_back_reads();
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog over reset plus all test budgets
    initial begin
        #((BUDGET_CYCLES + RST_CYCLES) * CLK_PERIOD);
        $display("Timeout: the tests did not finish within their cycle budget");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+test
src/acc_geom_pkg.sv
src/requant_pkg.sv
src/bank_ctrl.sv
src/accum_banks.sv
src/requant_stage.sv
src/accum_top.sv
test/tb_accum_top.sv
